// File: source/soc_io_consts.svh
`ifndef SOC_IO_CONSTS_SVH
`define SOC_IO_CONSTS_SVH

// Bus and datapath widths
`define IO_WORD_W   16
`define IO_ADDR_W   16
`define TICK_W      48
`define TIMER_W     32
`define PIOS_W      5
`define RAM_ADDR_W  14

// Interrupt lines
`define IRQ_N       8
`define EXT_IRQ_N   4
`define TIMER_IRQ   7
`define SYNC_STAGES 3

// I/O register map
`define ADDR_PIOS        16'd8
`define ADDR_INT_FLAGS   16'd40
`define ADDR_INT_MASK    16'd50

// Sampled tick count, low word first
`define ADDR_TICKS_L     16'd105
`define ADDR_TICKS_H     16'd106
`define ADDR_TICKS_HH    16'd107
`define ADDR_TICK_SAMPLE 16'd109
`define ADDR_TIMER1_L    16'd110
`define ADDR_TIMER1_H    16'd111

`define ADDR_PORTA_IN    16'd310
`define ADDR_PORTA_OUT   16'd311
`define ADDR_PORTA_DIR   16'd312
`define ADDR_SRAM_DATA   16'd600
`define ADDR_SRAM_ADDR   16'd601

`endif

// File: source/soc_io_pkg.sv
`default_nettype none

`include "soc_io_consts.svh"

package soc_io_pkg;

  // Bus word and address
  typedef logic [`IO_WORD_W-1:0]  word_t;
  typedef logic [`IO_ADDR_W-1:0]  io_addr_t;

  // Counters
  typedef logic [`TICK_W-1:0]     tick_t;
  typedef logic [`TIMER_W-1:0]    timer_t;

  // One bit per interrupt line
  typedef logic [`IRQ_N-1:0]      irq_vec_t;
  typedef logic [`EXT_IRQ_N-1:0]  ext_irq_t;

  typedef logic [`PIOS_W-1:0]     pios_t;
  typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;

endpackage

`default_nettype wire

// File: source/io_bus_if.sv
`default_nettype none

// One slave's view of the CPU I/O bus
interface io_bus_if
  import soc_io_pkg::*;
();

  logic     wr;
  io_addr_t addr;
  word_t    wdata;
  word_t    rdata;

  modport master (
    output wr, addr, wdata,
    input  rdata
  );

  modport slave (
    input  wr, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: source/irq_ctrl.sv
`default_nettype none

`include "soc_io_consts.svh"

module irq_ctrl
  import soc_io_pkg::*;
(
  input  logic     clk,
  input  logic     resetq,
  input  ext_irq_t ext_irq,
  input  logic     timer_hit,
  io_bus_if.slave  bus,
  output logic     timer_pending,
  output irq_vec_t irq_rqst
);

  ext_irq_t sync_q [`SYNC_STAGES];
  ext_irq_t ext_rise;
  irq_vec_t set_vec;
  irq_vec_t pending_q;
  irq_vec_t mask_q;
  irq_vec_t flags_q;

  // Shift register synchronizer with one column per external line
  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      for (int i = 0; i < `SYNC_STAGES; i++)
      begin
        sync_q[i] <= '0;
      end
    end
    else
    begin
      sync_q[0] <= ext_irq;
      for (int i = 1; i < `SYNC_STAGES; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Rising edge seen between the last two stages
  assign ext_rise = sync_q[`SYNC_STAGES-2] & ~sync_q[`SYNC_STAGES-1];

  always_comb
  begin
    set_vec = '0;
    set_vec[`EXT_IRQ_N-1:0] = ext_rise;
    set_vec[`TIMER_IRQ] = timer_hit;
  end

  // A set wins over a cleared flag in the same cycle
  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      pending_q <= '0;
      mask_q    <= '0;
      flags_q   <= '1;
    end
    else
    begin
      pending_q <= set_vec | (pending_q & flags_q);
      if (bus.wr && (bus.addr == `ADDR_INT_MASK))
        mask_q <= bus.wdata[`IRQ_N-1:0];
      if (bus.wr && (bus.addr == `ADDR_INT_FLAGS))
        flags_q <= bus.wdata[`IRQ_N-1:0];
    end
  end

  always_comb
  begin
    case (bus.addr)
      `ADDR_INT_FLAGS: bus.rdata = word_t'(flags_q);
      `ADDR_INT_MASK:  bus.rdata = word_t'(mask_q);
      default:         bus.rdata = '0;
    endcase
  end

  assign irq_rqst      = pending_q & mask_q;
  assign timer_pending = pending_q[`TIMER_IRQ];

  // Timer hits arrive only while the timer line is idle
  a_hit_when_idle: assert property (@(posedge clk) disable iff (!resetq)
    timer_hit |-> !timer_pending)
    else $error("irq_ctrl: timer_hit while the timer line is pending");

endmodule

`default_nettype wire

// File: source/sys_timers.sv
`default_nettype none

`include "soc_io_consts.svh"

module sys_timers
  import soc_io_pkg::*;
(
  input  logic    clk,
  input  logic    resetq,
  input  logic    timer_pending,
  io_bus_if.slave bus,
  output logic    timer_hit
);

  tick_t  ticks_q;
  tick_t  sample_q;
  timer_t reload_q;
  timer_t timer_q;
  logic   load_wr;

  // Writing the high half starts the timer
  assign load_wr = bus.wr && (bus.addr == `ADDR_TIMER1_H);

  always_ff @(posedge clk)
  begin
    if (!resetq)
      ticks_q <= '0;
    else
      ticks_q <= ticks_q + 1'b1;
  end

  // Snapshot of the free-running count
  always_ff @(posedge clk)
  begin
    if (bus.wr && (bus.addr == `ADDR_TICK_SAMPLE))
      sample_q <= ticks_q;
  end

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      reload_q <= '0;
      timer_q  <= '0;
    end
    else
    begin
      if (bus.wr && (bus.addr == `ADDR_TIMER1_L))
        reload_q[`IO_WORD_W-1:0] <= bus.wdata;
      if (load_wr)
        reload_q[`TIMER_W-1:`IO_WORD_W] <= bus.wdata;

      // Load uses the half on the bus, not the stored one
      if (load_wr)
        timer_q <= {bus.wdata, reload_q[`IO_WORD_W-1:0]};
      else if (timer_pending)
        timer_q <= reload_q;
      else
        timer_q <= timer_q - 1'b1;
    end
  end

  assign timer_hit = (timer_q == timer_t'(1)) && !timer_pending;

  always_comb
  begin
    case (bus.addr)
      `ADDR_TICKS_L:  bus.rdata = sample_q[`IO_WORD_W-1:0];
      `ADDR_TICKS_H:  bus.rdata = sample_q[2*`IO_WORD_W-1:`IO_WORD_W];
      `ADDR_TICKS_HH: bus.rdata = sample_q[3*`IO_WORD_W-1:2*`IO_WORD_W];
      default:        bus.rdata = '0;
    endcase
  end

  // Pending bit 7 in irq_ctrl must set right after a hit
  a_hit_single: assert property (@(posedge clk) disable iff (!resetq)
    timer_hit |=> !timer_hit)
    else $error("sys_timers: timer_hit held for two cycles");

endmodule

`default_nettype wire

// File: source/port_regs.sv
`default_nettype none

`include "soc_io_consts.svh"

module port_regs
  import soc_io_pkg::*;
(
  input  logic    clk,
  input  logic    resetq,
  input  word_t   porta_in,
  io_bus_if.slave bus,
  output word_t   porta_out,
  output word_t   porta_dir,
  output pios_t   pios
);

  // Direction bit 1 drives the pin
  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      porta_out <= '0;
      porta_dir <= '0;
      pios      <= '0;
    end
    else if (bus.wr)
    begin
      case (bus.addr)
        `ADDR_PORTA_OUT: porta_out <= bus.wdata;
        `ADDR_PORTA_DIR: porta_dir <= bus.wdata;
        `ADDR_PIOS:      pios      <= bus.wdata[`PIOS_W-1:0];
        default:
        begin
        end
      endcase
    end
  end

  // Raw pin state, no synchronizer
  always_comb
  begin
    case (bus.addr)
      `ADDR_PORTA_IN:  bus.rdata = porta_in;
      `ADDR_PORTA_OUT: bus.rdata = porta_out;
      `ADDR_PORTA_DIR: bus.rdata = porta_dir;
      `ADDR_PIOS:      bus.rdata = word_t'(pios);
      default:         bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/scratch_ram.sv
`default_nettype none

`include "soc_io_consts.svh"

module scratch_ram
  import soc_io_pkg::*;
#(
  parameter int ADDR_W = `RAM_ADDR_W
)
(
  input  logic    clk,
  input  logic    resetq,
  io_bus_if.slave bus
);

  logic [ADDR_W-1:0] addr_q;
  word_t             data_q;
  logic              we_q;
  word_t             rd_q;
  word_t             mem [2**ADDR_W];

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      addr_q <= '0;
      we_q   <= 1'b0;
    end
    else
    begin
      if (bus.wr && (bus.addr == `ADDR_SRAM_ADDR))
        addr_q <= bus.wdata[ADDR_W-1:0];
      we_q <= bus.wr && (bus.addr == `ADDR_SRAM_DATA);
    end
  end

  // Write data staged one cycle ahead of the array
  always_ff @(posedge clk)
  begin
    if (bus.wr && (bus.addr == `ADDR_SRAM_DATA))
      data_q <= bus.wdata;
    if (we_q)
      mem[addr_q] <= data_q;
    rd_q <= mem[addr_q];
  end

  assign bus.rdata = (bus.addr == `ADDR_SRAM_DATA) ? rd_q : '0;

  // CPU stores to the data port are never back to back
  a_we_single: assert property (@(posedge clk) disable iff (!resetq)
    we_q |=> !we_q)
    else $error("scratch_ram: write enable held for two cycles");

endmodule

`default_nettype wire

// File: source/soc_io.sv
`default_nettype none

module soc_io
  import soc_io_pkg::*;
(
  input  logic     clk,
  input  logic     resetq,
  input  logic     io_wr,
  input  io_addr_t io_addr,
  input  word_t    io_wdata,
  output word_t    io_rdata,
  input  ext_irq_t ext_irq,
  input  word_t    porta_in,
  output irq_vec_t irq_rqst,
  output word_t    porta_out,
  output word_t    porta_dir,
  output pios_t    pios
);

  logic timer_hit;
  logic timer_pending;

  // One bus view per slave
  io_bus_if bus_irq ();
  io_bus_if bus_tmr ();
  io_bus_if bus_port ();
  io_bus_if bus_ram ();

  assign bus_irq.wr     = io_wr;
  assign bus_irq.addr   = io_addr;
  assign bus_irq.wdata  = io_wdata;
  assign bus_tmr.wr     = io_wr;
  assign bus_tmr.addr   = io_addr;
  assign bus_tmr.wdata  = io_wdata;
  assign bus_port.wr    = io_wr;
  assign bus_port.addr  = io_addr;
  assign bus_port.wdata = io_wdata;
  assign bus_ram.wr     = io_wr;
  assign bus_ram.addr   = io_addr;
  assign bus_ram.wdata  = io_wdata;

  // Unowned addresses read as zero in every slave
  assign io_rdata = bus_irq.rdata | bus_tmr.rdata | bus_port.rdata | bus_ram.rdata;

  irq_ctrl i_irq_ctrl (
    .clk           (clk),
    .resetq        (resetq),
    .ext_irq       (ext_irq),
    .timer_hit     (timer_hit),
    .bus           (bus_irq),
    .timer_pending (timer_pending),
    .irq_rqst      (irq_rqst)
  );

  sys_timers i_sys_timers (
    .clk           (clk),
    .resetq        (resetq),
    .timer_pending (timer_pending),
    .bus           (bus_tmr),
    .timer_hit     (timer_hit)
  );

  port_regs i_port_regs (
    .clk       (clk),
    .resetq    (resetq),
    .porta_in  (porta_in),
    .bus       (bus_port),
    .porta_out (porta_out),
    .porta_dir (porta_dir),
    .pios      (pios)
  );

  scratch_ram i_scratch_ram (
    .clk    (clk),
    .resetq (resetq),
    .bus    (bus_ram)
  );

endmodule

`default_nettype wire

// File: tb/tb_soc_io.sv
`default_nettype none

`include "soc_io_consts.svh"

module tb_soc_io;

  localparam int OP_WR = 0;
  localparam int OP_RD = 1;
  localparam int OP_DRV = 2;
  localparam int OP_WAIT = 3;
  localparam int OP_OUT = 4;
  localparam int OP_IRQ = 5;
  localparam int OP_SAMPLE = 6;

  typedef struct packed {
    int          op;
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] exp;
    int          gap;
  } row_t;

  logic        clk;
  logic        resetq;
  logic        io_wr;
  logic [15:0] io_addr;
  logic [15:0] io_wdata;
  logic [15:0] io_rdata;
  logic [3:0]  ext_irq;
  logic [15:0] porta_in;
  logic [7:0]  irq_rqst;
  logic [15:0] porta_out;
  logic [15:0] porta_dir;
  logic [4:0]  pios;

  row_t        rows[$];
  integer      seed = 38;
  int          errors = 0;
  int          cyc = 0;
  int          limit = 0;
  int          last_cyc = 0;
  int          prev_cyc = 0;
  logic [47:0] prev_tick = '0;
  bit          have_prev = 1'b0;

  soc_io i_soc_io (
    .clk       (clk),
    .resetq    (resetq),
    .io_wr     (io_wr),
    .io_addr   (io_addr),
    .io_wdata  (io_wdata),
    .io_rdata  (io_rdata),
    .ext_irq   (ext_irq),
    .porta_in  (porta_in),
    .irq_rqst  (irq_rqst),
    .porta_out (porta_out),
    .porta_dir (porta_dir),
    .pios      (pios)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if ((limit != 0) && (cyc >= limit))
    begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic void add_row(int op, logic [15:0] addr, logic [15:0] data,
                                  logic [15:0] exp, int gap);
    rows.push_back('{op, addr, data, exp, gap});
  endfunction

  task automatic check_value(string name, logic [15:0] addr, logic [15:0] got,
                             logic [15:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERROR: %s addr=0x%h got=0x%h exp=0x%h", name, addr, got, exp);
    end
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    logic [15:0] ram_a[4];
    logic [15:0] ram_d[4];
    rnd = $random(seed);
    // Port registers, pins, mask and flags readback
    add_row(OP_WR, `ADDR_PORTA_OUT, 16'h5ac3, 16'h0, 0);
    add_row(OP_WR, `ADDR_PORTA_DIR, 16'h0ff0, 16'h0, 0);
    add_row(OP_WR, `ADDR_PIOS, 16'h0015, 16'h0, 0);
    add_row(OP_RD, `ADDR_PORTA_OUT, 16'h0, 16'h5ac3, 0);
    add_row(OP_RD, `ADDR_PORTA_DIR, 16'h0, 16'h0ff0, 0);
    add_row(OP_RD, `ADDR_PIOS, 16'h0, 16'h0015, 0);
    add_row(OP_OUT, `ADDR_PORTA_OUT, 16'h0, 16'h5ac3, 0);
    add_row(OP_OUT, `ADDR_PORTA_DIR, 16'h0, 16'h0ff0, 0);
    add_row(OP_OUT, `ADDR_PIOS, 16'h0, 16'h0015, 0);
    add_row(OP_DRV, `ADDR_PORTA_IN, rnd[15:0], 16'h0, 0);
    add_row(OP_RD, `ADDR_PORTA_IN, 16'h0, rnd[15:0], 0);
    add_row(OP_WR, `ADDR_INT_MASK, 16'h00a5, 16'h0, 0);
    add_row(OP_RD, `ADDR_INT_MASK, 16'h0, 16'h00a5, 0);
    add_row(OP_WR, `ADDR_INT_FLAGS, 16'h005a, 16'h0, 0);
    add_row(OP_RD, `ADDR_INT_FLAGS, 16'h0, 16'h005a, 0);
    add_row(OP_WR, `ADDR_INT_FLAGS, 16'h00ff, 16'h0, 0);
    // Line 0 enabled, line 1 masked; the bit 0 rise must not be delayed by a gap
    add_row(OP_WR, `ADDR_INT_MASK, 16'h0001, 16'h0, 0);
    add_row(OP_DRV, 16'h0, 16'h0001, 16'h0, 0);
    add_row(OP_WAIT, 16'h0, 16'h0001, 16'd3, 8);
    add_row(OP_DRV, 16'h0, 16'h0003, 16'h0, 4);
    add_row(OP_IRQ, 16'h0, 16'h0002, 16'h0, 0);
    add_row(OP_WR, `ADDR_INT_FLAGS, 16'h00fe, 16'h0, 0);
    add_row(OP_WR, `ADDR_INT_FLAGS, 16'h00ff, 16'h0, 0);
    add_row(OP_IRQ, 16'h0, 16'h0001, 16'h0, 0);
    add_row(OP_DRV, 16'h0, 16'h0000, 16'h0, 0);
    // Reload 20, first hit 20 cycles after the high half
    add_row(OP_WR, `ADDR_INT_MASK, 16'h0081, 16'h0, 0);
    add_row(OP_WR, `ADDR_TIMER1_L, 16'd20, 16'h0, 0);
    add_row(OP_WR, `ADDR_TIMER1_H, 16'h0, 16'h0, 0);
    add_row(OP_WAIT, 16'h0, 16'h0080, 16'd20, 25);
    add_row(OP_WR, `ADDR_INT_FLAGS, 16'h007f, 16'h0, 0);
    add_row(OP_IRQ, 16'h0, 16'h0080, 16'h0, 0);
    add_row(OP_WR, `ADDR_INT_FLAGS, 16'h00ff, 16'h0, 0);
    add_row(OP_WAIT, 16'h0, 16'h0080, 16'h0, 30);
    add_row(OP_SAMPLE, 16'h0, 16'h0, 16'h0, 25);
    add_row(OP_SAMPLE, 16'h0, 16'h0, 16'h0, 7);
    add_row(OP_SAMPLE, 16'h0, 16'h0, 16'h0, 0);
    // Top two address bits keep the four RAM words apart
    for (int i = 0; i < 4; i++)
    begin
      rnd = $random(seed);
      ram_a[i] = {2'b00, i[1:0], rnd[11:0]};
      ram_d[i] = rnd[31:16];
      add_row(OP_WR, `ADDR_SRAM_ADDR, ram_a[i], 16'h0, 0);
      add_row(OP_WR, `ADDR_SRAM_DATA, ram_d[i], 16'h0, 0);
    end
    for (int i = 0; i < 4; i++)
    begin
      add_row(OP_WR, `ADDR_SRAM_ADDR, ram_a[i], 16'h0, 0);
      add_row(OP_RD, `ADDR_SRAM_DATA, 16'h0, ram_d[i], 0);
    end
  endtask

  task automatic run_row(input row_t r);
    int          n;
    logic [47:0] tick;
    n = 0;
    case (r.op)
      OP_WR, OP_SAMPLE:
      begin
        io_wr    <= 1'b1;
        io_addr  <= (r.op == OP_SAMPLE) ? `ADDR_TICK_SAMPLE : r.addr;
        io_wdata <= r.data;
        @(posedge clk);
        io_wr <= 1'b0;
        if (r.op == OP_SAMPLE)
          io_addr <= `ADDR_TICKS_L;
        @(negedge clk);
        last_cyc = cyc;
        if (r.op == OP_SAMPLE)
        begin
          tick[15:0] = io_rdata;
          @(posedge clk);
          io_addr <= `ADDR_TICKS_H;
          @(negedge clk);
          tick[31:16] = io_rdata;
          @(posedge clk);
          io_addr <= `ADDR_TICKS_HH;
          @(negedge clk);
          tick[47:32] = io_rdata;
          check_value("io_rdata", `ADDR_TICKS_HH, tick[47:32], 16'h0000);
          // Sample delta equals the cycles between the two sample writes
          if (have_prev)
          begin
            assert ((tick - prev_tick) == 48'(last_cyc - prev_cyc))
            else
            begin
              errors++;
              $display("ERROR: tick delta got=0x%h exp=0x%h", tick - prev_tick,
                       48'(last_cyc - prev_cyc));
            end
          end
          have_prev = 1'b1;
          prev_tick = tick;
          prev_cyc  = last_cyc;
        end
      end
      OP_RD:
      begin
        io_addr <= r.addr;
        @(negedge clk);
        check_value("io_rdata", r.addr, io_rdata, r.exp);
      end
      OP_DRV:
      begin
        if (r.addr == `ADDR_PORTA_IN)
          porta_in <= r.data;
        else
          ext_irq <= r.data[3:0];
        @(negedge clk);
        last_cyc = cyc;
      end
      OP_OUT:
      begin
        @(negedge clk);
        if (r.addr == `ADDR_PORTA_OUT)
          check_value("porta_out", r.addr, porta_out, r.exp);
        else if (r.addr == `ADDR_PORTA_DIR)
          check_value("porta_dir", r.addr, porta_dir, r.exp);
        else
          check_value("pios", r.addr, {11'b0, pios}, r.exp);
      end
      OP_IRQ:
      begin
        @(negedge clk);
        check_value("irq_rqst", r.addr, {8'h00, irq_rqst & r.data[7:0]}, r.exp);
      end
      OP_WAIT:
      begin
        @(negedge clk);
        while (((irq_rqst & r.data[7:0]) == 8'h00) && (n < r.gap))
        begin
          @(negedge clk);
          n++;
        end
        assert ((irq_rqst & r.data[7:0]) != 8'h00)
        else
        begin
          errors++;
          $display("Interrupt 0x%h did not arrive within %0d cycles", r.data[7:0], r.gap);
        end
        // Latency counted from the last write or input change
        if (((irq_rqst & r.data[7:0]) != 8'h00) && (r.exp != 16'h0))
          check_value("irq_rqst latency", r.addr, 16'(cyc - last_cyc), r.exp);
      end
      default:
      begin
        errors++;
        $display("Stimulus table holds an unknown operation %0d", r.op);
      end
    endcase
  endtask

  initial
  begin
    int total;
    total    = 0;
    resetq   = 1'b0;
    io_wr    = 1'b0;
    io_addr  = '0;
    io_wdata = '0;
    ext_irq  = '0;
    porta_in = '0;
    build_table();
    foreach (rows[i])
      total += rows[i].gap;
    limit = total + 3 * rows.size() + 200;
    repeat (8) @(posedge clk);
    resetq <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < rows.size(); i++)
    begin
      run_row(rows[i]);
      if (rows[i].op == OP_WAIT)
        repeat (3) @(posedge clk);
      else
        repeat (rows[i].gap + 3) @(posedge clk);
    end
    $display("Run complete: %0d rows, %0d errors", rows.size(), errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: soc_io.f
+incdir+source
source/soc_io_pkg.sv
source/io_bus_if.sv
source/irq_ctrl.sv
source/sys_timers.sv
source/port_regs.sv
source/scratch_ram.sv
source/soc_io.sv
tb/tb_soc_io.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

TOP=tb_soc_io
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -o "sim_$TOP" \
  -f soc_io.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench prints its fail line on any failed check or timeout
if grep -q "=== FAIL ===" "$LOG"; then
  echo "Testbench reported a failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
